/* Makefile */
# Verilator build and run of the sideband header encoder testbench

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f files.f \
		--top-module tb_sb_header_encoder -Mdir obj_dir -o tb_sim
	./obj_dir/tb_sim > sim.log 2>&1; cat sim.log
	@if grep -q "Simulation failed" sim.log; then \
		echo "Result: FAIL"; exit 1; \
	fi
	@grep -q "Simulation completed successfully" sim.log || \
		(echo "Result: run ended early"; exit 1)
	@echo "Result: PASS"

clean:
	rm -rf obj_dir sim.log

/* files.f */
+incdir+hw
hw/sb_pkg.sv
hw/sb_msg_decode.sv
hw/sb_subcode_seq.sv
hw/sb_field_enc.sv
hw/sb_header_pack.sv
hw/sb_header_encoder.sv
sim/sb_header_encoder_sva.sv
sim/tb_sb_header_encoder.sv

/* hw/sb_defines.svh */
`ifndef SB_DEFINES_SVH
`define SB_DEFINES_SVH

// Fixed sideband endpoint IDs
`define SB_SRCID                3'd2
`define SB_DSTID                3'd6

// Field widths
`define SB_MSG_NO_W             4
`define SB_INFO_W               16

// Out-of-reset message number in SBINIT
`define SB_OUT_OF_RESET_MSG_NO  4'd3

// Point/sweep results response
`define SB_RESULTS_MSG_NO       4'd6

// RX sweep done, last message of the sweep
`define SB_SWEEP_DONE_MSG_NO    4'd9

`endif

/* hw/sb_field_enc.sv */
`timescale 1ns/10ps
`default_nettype none

`include "sb_defines.svh"

module sb_field_enc (
	input  wire                     i_clk,
	input  wire                     i_rst_n,
	input  wire                     i_msg_valid,
	input  wire sb_pkg::ltsm_msg_t  i_ltsm,
	input  wire sb_pkg::rdi_msg_t   i_rdi,
	input  wire sb_pkg::msg_class_t i_class,
	output sb_pkg::hdr_fields_t     o_fields,
	output logic                    o_fields_valid
);

	import sb_pkg::*;

	hdr_fields_t fields_nxt;

	// Message code nibbles for LTSM
	logic [3:0] code_hi;
	logic [3:0] code_lo;

	// ----------------------------------------------------------------------
	// LTSM message code
	// ----------------------------------------------------------------------
	always_comb begin
		if (i_class.is_test) begin
			code_hi = 4'h8;
		end else begin
			case (i_ltsm.state)
				ST_SBINIT:        code_hi = 4'h9;
				ST_MBINIT:        code_hi = 4'hA;
				ST_MBTRAIN:       code_hi = 4'hB;
				ST_TRAINERROR_HS: code_hi = 4'hE;
				ST_PHYRETRAIN:    code_hi = 4'hC;
				default:          code_hi = 4'h0;
			endcase
		end
		// Out-of-reset and sweep done share code 1
		if (i_class.is_test ? i_class.is_sweep_done : i_class.is_out_of_reset) begin
			code_lo = 4'h1;
		end else if (i_class.is_req) begin
			code_lo = 4'h5;
		end else begin
			code_lo = 4'hA;
		end
	end

	// ----------------------------------------------------------------------
	// Field selection, LTSM or RDI
	// ----------------------------------------------------------------------
	always_comb begin
		fields_nxt = '0;
		if (i_class.is_rdi) begin
			fields_nxt.opcode   = OP_MSG_NO_DATA;
			fields_nxt.msg_code = {6'h00, i_rdi.code};
			case (i_rdi.code)
				// NOP info 0..3 goes out as 1..4
				RDI_NOP:  fields_nxt.msg_info = {{(`SB_INFO_W-2){1'b0}}, i_rdi.info} + 1'b1;
				RDI_RESP: fields_nxt.msg_info = {`SB_INFO_W{i_rdi.info[0]}};
				default:  fields_nxt.msg_info = '0;
			endcase
		end else begin
			fields_nxt.opcode   = i_ltsm.data_valid ? OP_MSG_WITH_DATA : OP_MSG_NO_DATA;
			fields_nxt.msg_code = {code_hi, code_lo};
			if (i_class.is_results_resp) begin
				// Result bits sit at 5:4
				fields_nxt.msg_info = {{(`SB_INFO_W-6){1'b0}}, i_ltsm.msg_info[1:0], 4'h0};
			end else begin
				fields_nxt.msg_info = {{(`SB_INFO_W-3){1'b0}}, i_ltsm.msg_info};
			end
		end
	end

	// Stage valid
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_fields_valid <= 1'b0;
		end else begin
			o_fields_valid <= i_msg_valid;
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_msg_valid) begin
			o_fields <= fields_nxt;
		end
	end

endmodule : sb_field_enc

`default_nettype wire

/* hw/sb_header_encoder.sv */
`timescale 1ns/10ps
`default_nettype none

module sb_header_encoder (
	input  wire                    i_clk,
	input  wire                    i_rst_n,
	input  wire                    i_msg_valid,
	input  wire                    i_rdi_msg,
	input  wire sb_pkg::ltsm_msg_t i_ltsm,
	input  wire sb_pkg::rdi_msg_t  i_rdi,
	output sb_pkg::sb_header_t     o_header,
	output logic                   o_header_valid
);

	import sb_pkg::*;

	// Decode to execute
	msg_class_t  msg_class;

	// Execute to result
	logic [7:0]  subcode;
	hdr_fields_t fields;
	logic        fields_valid;

	// ----------------------------------------------------------------------
	// Decode, combinational
	// ----------------------------------------------------------------------
	sb_msg_decode u_decode (
		.i_clk       (i_clk),
		.i_rst_n     (i_rst_n),
		.i_msg_valid (i_msg_valid),
		.i_rdi_msg   (i_rdi_msg),
		.i_ltsm      (i_ltsm),
		.o_class     (msg_class)
	);

	// ----------------------------------------------------------------------
	// Execute, one cycle
	// ----------------------------------------------------------------------
	sb_subcode_seq u_subcode (
		.i_clk       (i_clk),
		.i_rst_n     (i_rst_n),
		.i_msg_valid (i_msg_valid),
		.i_ltsm      (i_ltsm),
		.i_rdi       (i_rdi),
		.i_class     (msg_class),
		.o_subcode   (subcode)
	);

	sb_field_enc u_fields (
		.i_clk          (i_clk),
		.i_rst_n        (i_rst_n),
		.i_msg_valid    (i_msg_valid),
		.i_ltsm         (i_ltsm),
		.i_rdi          (i_rdi),
		.i_class        (msg_class),
		.o_fields       (fields),
		.o_fields_valid (fields_valid)
	);

	// Result, one more cycle
	sb_header_pack u_pack (
		.i_clk          (i_clk),
		.i_rst_n        (i_rst_n),
		.i_fields       (fields),
		.i_fields_valid (fields_valid),
		.i_subcode      (subcode),
		.o_header       (o_header),
		.o_header_valid (o_header_valid)
	);

endmodule : sb_header_encoder

`default_nettype wire

/* hw/sb_header_pack.sv */
`timescale 1ns/10ps
`default_nettype none

`include "sb_defines.svh"

module sb_header_pack (
	input  wire                      i_clk,
	input  wire                      i_rst_n,
	input  wire sb_pkg::hdr_fields_t i_fields,
	input  wire                      i_fields_valid,
	input  wire [7:0]                i_subcode,
	output sb_pkg::sb_header_t       o_header,
	output logic                     o_header_valid
);

	import sb_pkg::*;

	sb_header_t hdr_nxt;

	// Header layout, reserved bits zero
	always_comb begin
		hdr_nxt            = '0;
		hdr_nxt.dstid      = `SB_DSTID;
		hdr_nxt.info       = i_fields.msg_info;
		hdr_nxt.subcode    = i_subcode;
		hdr_nxt.srcid      = `SB_SRCID;
		hdr_nxt.msg_code   = i_fields.msg_code;
		hdr_nxt.opcode     = i_fields.opcode;
	end

	// ----------------------------------------------------------------------
	// Output stage
	// ----------------------------------------------------------------------
	// Header holds between messages
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_header       <= '0;
			o_header_valid <= 1'b0;
		end else begin
			o_header_valid <= i_fields_valid;
			if (i_fields_valid) begin
				o_header <= hdr_nxt;
			end
		end
	end

endmodule : sb_header_pack

`default_nettype wire

/* hw/sb_msg_decode.sv */
`timescale 1ns/10ps
`default_nettype none

`include "sb_defines.svh"

module sb_msg_decode (
	input  wire                i_clk,
	input  wire                i_rst_n,
	input  wire                i_msg_valid,
	input  wire                i_rdi_msg,
	input  wire sb_pkg::ltsm_msg_t i_ltsm,
	output sb_pkg::msg_class_t o_class
);

	import sb_pkg::*;

	// State of the last LTSM message taken
	ltsm_state_e last_state;

	// Flags for the LTSM path only
	logic ltsm_sel;
	logic oor_msg;
	logic state_chg;

	assign ltsm_sel  = !i_rdi_msg;
	assign oor_msg   = (i_ltsm.state == ST_SBINIT) &&
		(i_ltsm.msg_no == `SB_OUT_OF_RESET_MSG_NO);
	assign state_chg = (i_ltsm.state != last_state);

	// ----------------------------------------------------------------------
	// Classification, same cycle as the message
	// ----------------------------------------------------------------------
	always_comb begin
		o_class                 = '0;
		o_class.is_rdi          = i_rdi_msg;
		// Odd message numbers are requests
		o_class.is_req          = ltsm_sel && i_ltsm.msg_no[0];
		o_class.is_test         = ltsm_sel && i_ltsm.test_en;
		o_class.is_out_of_reset = ltsm_sel && oor_msg;
		o_class.restart         = ltsm_sel && (state_chg || oor_msg);
		// Counter frozen in TRAINERROR
		o_class.hold_count      = ltsm_sel && (i_ltsm.state == ST_TRAINERROR);
		// Results response of TX point or RX sweep
		o_class.is_results_resp = ltsm_sel && i_ltsm.test_en &&
			((i_ltsm.test == PST_TX_POINT) || (i_ltsm.test == PST_RX_SWEEP)) &&
			(i_ltsm.msg_no == `SB_RESULTS_MSG_NO);
		o_class.is_sweep_done   = ltsm_sel && i_ltsm.test_en &&
			(i_ltsm.msg_no == `SB_SWEEP_DONE_MSG_NO);
	end

	// ----------------------------------------------------------------------
	// Last-state tracking
	// ----------------------------------------------------------------------
	// RDI traffic leaves this alone
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			last_state <= ST_RESET;
		end else if (i_msg_valid && ltsm_sel) begin
			last_state <= i_ltsm.state;
		end
	end

endmodule : sb_msg_decode

`default_nettype wire

/* hw/sb_pkg.sv */
`default_nettype none

package sb_pkg;

	`include "sb_defines.svh"

	// ----------------------------------------------------------------------
	// Encodings
	// ----------------------------------------------------------------------

	// Training states, same numbering as the LTSM
	typedef enum logic [3:0] {
		ST_RESET            = 4'd0,
		ST_FINISH_RESET     = 4'd1,
		ST_SBINIT           = 4'd2,
		ST_MBINIT           = 4'd3,
		ST_MBTRAIN          = 4'd4,
		ST_LINKINIT         = 4'd5,
		ST_ACTIVE           = 4'd6,
		ST_TRAINERROR_HS    = 4'd7,
		ST_TRAINERROR       = 4'd8,
		ST_LINKMGMT_RETRAIN = 4'd9,
		ST_PHYRETRAIN       = 4'd10,
		ST_L1_L2            = 4'd11
	} ltsm_state_e;

	// Point/sweep test kinds
	typedef enum logic [1:0] {
		PST_TX_POINT = 2'd0,
		PST_TX_SWEEP = 2'd1,
		PST_RX_POINT = 2'd2,
		PST_RX_SWEEP = 2'd3
	} pst_test_e;

	// RDI message codes and subcodes
	typedef enum logic [1:0] {
		RDI_NOP  = 2'd0,
		RDI_REQ  = 2'd1,
		RDI_RESP = 2'd2
	} rdi_code_e;

	typedef enum logic [3:0] {
		RDI_CRD        = 4'd0,
		RDI_ACTIVE     = 4'd1,
		RDI_PMNAK      = 4'd2,
		RDI_L1         = 4'd3,
		RDI_L2         = 4'd4,
		RDI_LINK_RESET = 4'd5,
		RDI_LINK_ERROR = 4'd6,
		RDI_RETRAIN    = 4'd7,
		RDI_DISABLE    = 4'd8
	} rdi_subcode_e;

	// Sideband opcodes in use
	typedef enum logic [4:0] {
		OP_MSG_NO_DATA   = 5'h12,
		OP_MSG_WITH_DATA = 5'h1B
	} sb_opcode_e;

	// ----------------------------------------------------------------------
	// Bundles
	// ----------------------------------------------------------------------

	typedef struct packed {
		ltsm_state_e             state;
		logic [`SB_MSG_NO_W-1:0] msg_no;
		logic [2:0]              msg_info;
		logic                    data_valid;
		logic                    test_en;
		pst_test_e               test;
	} ltsm_msg_t;

	typedef struct packed {
		rdi_code_e    code;
		rdi_subcode_e subcode;
		logic [1:0]   info;
	} rdi_msg_t;

	// Per-message flags from the decoder
	typedef struct packed {
		logic is_rdi;
		logic is_req;
		logic is_test;
		logic restart;
		logic hold_count;
		logic is_results_resp;
		logic is_out_of_reset;
		logic is_sweep_done;
	} msg_class_t;

	typedef struct packed {
		sb_opcode_e             opcode;
		logic [7:0]             msg_code;
		logic [`SB_INFO_W-1:0]  msg_info;
	} hdr_fields_t;

	// Header word, msb first
	typedef struct packed {
		logic [2:0]            rsvd_61_59;
		logic [2:0]            dstid;
		logic [`SB_INFO_W-1:0] info;
		logic [7:0]            subcode;
		logic [2:0]            srcid;
		logic [6:0]            rsvd_28_22;
		logic [7:0]            msg_code;
		logic [8:0]            rsvd_13_5;
		sb_opcode_e            opcode;
	} sb_header_t;

endpackage : sb_pkg

`default_nettype wire

/* hw/sb_subcode_seq.sv */
`timescale 1ns/10ps
`default_nettype none

`include "sb_defines.svh"

module sb_subcode_seq (
	input  wire                    i_clk,
	input  wire                    i_rst_n,
	input  wire                    i_msg_valid,
	input  wire sb_pkg::ltsm_msg_t i_ltsm,
	input  wire sb_pkg::rdi_msg_t  i_rdi,
	input  wire sb_pkg::msg_class_t i_class,
	output logic [7:0]             o_subcode
);

	import sb_pkg::*;

	// Running subcode counter
	logic [7:0] cnt;
	logic [7:0] cnt_nxt;

	// Fixed subcode for point/sweep tests
	logic [7:0] pst_sub;

	// ----------------------------------------------------------------------
	// Point/sweep table, one entry per message pair
	// ----------------------------------------------------------------------
	always_comb begin
		pst_sub = 8'h00;
		case (i_ltsm.msg_no)
			4'd1, 4'd2: begin
				case (i_ltsm.test)
					PST_TX_POINT: pst_sub = 8'h01;
					PST_TX_SWEEP: pst_sub = 8'h05;
					PST_RX_POINT: pst_sub = 8'h07;
					PST_RX_SWEEP: pst_sub = 8'h0A;
					default:      pst_sub = 8'h00;
				endcase
			end
			// Common entry for every kind
			4'd3, 4'd4: pst_sub = 8'h02;
			4'd5, 4'd6: begin
				case (i_ltsm.test)
					PST_TX_POINT: pst_sub = 8'h03;
					PST_TX_SWEEP: pst_sub = 8'h06;
					PST_RX_POINT: pst_sub = 8'h08;
					PST_RX_SWEEP: pst_sub = 8'h0B;
					default:      pst_sub = 8'h00;
				endcase
			end
			// TX sweep has no fourth pair
			4'd7, 4'd8: begin
				case (i_ltsm.test)
					PST_TX_POINT: pst_sub = 8'h04;
					PST_RX_POINT: pst_sub = 8'h09;
					PST_RX_SWEEP: pst_sub = 8'h0D;
					default:      pst_sub = 8'h00;
				endcase
			end
			`SB_SWEEP_DONE_MSG_NO: begin
				if (i_ltsm.test == PST_RX_SWEEP) begin
					pst_sub = 8'h0C;
				end
			end
			default: pst_sub = 8'h00;
		endcase
	end

	// ----------------------------------------------------------------------
	// Counter update
	// ----------------------------------------------------------------------
	always_comb begin
		if (i_class.restart) begin
			cnt_nxt = 8'h00;
		end else if (i_class.is_req && !i_class.hold_count) begin
			cnt_nxt = cnt + 8'd1;
		end else begin
			// Responses and TRAINERROR keep the value
			cnt_nxt = cnt;
		end
	end

	// Only plain LTSM messages move the counter
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			cnt <= 8'h00;
		end else if (i_msg_valid && !i_class.is_rdi && !i_class.is_test) begin
			cnt <= cnt_nxt;
		end
	end

	// Subcode for this message
	always_ff @(posedge i_clk) begin
		if (i_msg_valid) begin
			if (i_class.is_rdi) begin
				o_subcode <= {4'h0, i_rdi.subcode};
			end else if (i_class.is_test) begin
				o_subcode <= pst_sub;
			end else begin
				o_subcode <= cnt_nxt;
			end
		end
	end

endmodule : sb_subcode_seq

`default_nettype wire

/* sim/sb_header_encoder_sva.sv */
`timescale 1ns/10ps
`default_nettype none

`include "sb_defines.svh"

module sb_header_encoder_sva (
	input wire                     i_clk,
	input wire                     i_rst_n,
	input wire                     i_msg_valid,
	input wire sb_pkg::sb_header_t i_header,
	input wire                     i_header_valid
);

	import sb_pkg::*;

	// ------------------------------------------------------------------
	// Output protocol
	// ------------------------------------------------------------------
	// Quiet while reset is held
	a_no_valid_in_reset: assert property (@(posedge i_clk)
		!i_rst_n |-> !i_header_valid)
		else $error("header valid while in reset");

	// Two-cycle latency from the message strobe
	a_valid_latency: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		i_header_valid |-> $past(i_msg_valid, 2))
		else $error("header valid without a message two cycles before");

	// Fixed endpoint IDs
	a_fixed_ids: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		i_header_valid |-> (i_header.srcid == `SB_SRCID) && (i_header.dstid == `SB_DSTID))
		else $error("srcid or dstid wrong in header");

	a_opcode_legal: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		i_header_valid |-> (i_header.opcode inside {OP_MSG_NO_DATA, OP_MSG_WITH_DATA}))
		else $error("illegal opcode in header");

endmodule : sb_header_encoder_sva

bind sb_header_encoder sb_header_encoder_sva u_sva (
	.i_clk          (i_clk),
	.i_rst_n        (i_rst_n),
	.i_msg_valid    (i_msg_valid),
	.i_header       (o_header),
	.i_header_valid (o_header_valid)
);

`default_nettype wire

/* sim/tb_sb_header_encoder.sv */
`timescale 1ns/10ps
`default_nettype none

`include "sb_defines.svh"

module tb_sb_header_encoder;

	import sb_pkg::*;

	localparam int NUM_VEC        = 29;
	// Worst case is one message plus two idles per entry
	localparam int TIMEOUT_CYCLES = NUM_VEC * 3 + 20;

	// One stimulus line and its expected header
	typedef struct packed {
		logic       rdi;
		logic       b2b;
		ltsm_msg_t  ltsm;
		rdi_msg_t   rdi_msg;
		sb_header_t hdr;
	} vec_t;

	// DUT ports
	logic       i_clk;
	logic       i_rst_n;
	logic       i_msg_valid;
	logic       i_rdi_msg;
	ltsm_msg_t  i_ltsm;
	rdi_msg_t   i_rdi;
	sb_header_t o_header;
	logic       o_header_valid;

	// Table, scoreboard and counters
	vec_t       tbl [NUM_VEC];
	int         n_vec;
	int         idx;
	int         gaps;
	logic       b2b_mode;
	sb_header_t exp_q [$];
	sb_header_t exp_hdr;
	int         rx_count;
	int         cycle_cnt;
	int         hdr_errs;
	int         cnt_errs;

	sb_header_encoder u_dut (
		.i_clk          (i_clk),
		.i_rst_n        (i_rst_n),
		.i_msg_valid    (i_msg_valid),
		.i_rdi_msg      (i_rdi_msg),
		.i_ltsm         (i_ltsm),
		.i_rdi          (i_rdi),
		.o_header       (o_header),
		.o_header_valid (o_header_valid)
	);

	// 100 ns clock
	initial i_clk = 1'b0;
	always #50 i_clk = ~i_clk;

	// ------------------------------------------------------------------
	// Table building
	// ------------------------------------------------------------------
	function automatic sb_header_t make_header(input sb_opcode_e op, input logic [7:0] code,
		input logic [7:0] sub, input logic [15:0] info);
		sb_header_t h;
		h          = '0;
		h.dstid    = `SB_DSTID;
		h.srcid    = `SB_SRCID;
		h.opcode   = op;
		h.msg_code = code;
		h.subcode  = sub;
		h.info     = info;
		return h;
	endfunction

	// Plain LTSM message, opcode follows data_valid
	task automatic add_ltsm(input ltsm_state_e st, input logic [3:0] no, input logic [2:0] info,
		input logic dv, input logic [7:0] code, input logic [7:0] sub, input logic [15:0] xinfo);
		vec_t v;
		v                 = '0;
		v.b2b             = b2b_mode;
		v.ltsm.state      = st;
		v.ltsm.msg_no     = no;
		v.ltsm.msg_info   = info;
		v.ltsm.data_valid = dv;
		v.hdr = make_header(dv ? OP_MSG_WITH_DATA : OP_MSG_NO_DATA, code, sub, xinfo);
		tbl[n_vec] = v;
		n_vec++;
	endtask

	// Point/sweep test, sent while in MBINIT
	task automatic add_test(input pst_test_e kind, input logic [3:0] no, input logic [2:0] info,
		input logic [7:0] code, input logic [7:0] sub, input logic [15:0] xinfo);
		vec_t v;
		v               = '0;
		v.b2b           = b2b_mode;
		v.ltsm.state    = ST_MBINIT;
		v.ltsm.msg_no   = no;
		v.ltsm.msg_info = info;
		v.ltsm.test_en  = 1'b1;
		v.ltsm.test     = kind;
		v.hdr           = make_header(OP_MSG_NO_DATA, code, sub, xinfo);
		tbl[n_vec] = v;
		n_vec++;
	endtask

	task automatic add_rdi(input rdi_code_e c, input rdi_subcode_e s, input logic [1:0] info,
		input logic [7:0] code, input logic [7:0] sub, input logic [15:0] xinfo);
		vec_t v;
		v                 = '0;
		v.b2b             = b2b_mode;
		v.rdi             = 1'b1;
		v.rdi_msg.code    = c;
		v.rdi_msg.subcode = s;
		v.rdi_msg.info    = info;
		v.hdr             = make_header(OP_MSG_NO_DATA, code, sub, xinfo);
		tbl[n_vec] = v;
		n_vec++;
	endtask

	task automatic build_table();
		// Out of reset, then counting in SBINIT
		add_ltsm(ST_SBINIT, 4'd3, 3'd0, 1'b0, 8'h91, 8'h00, 16'h0000);
		add_ltsm(ST_SBINIT, 4'd1, 3'd0, 1'b0, 8'h95, 8'h01, 16'h0000);
		add_ltsm(ST_SBINIT, 4'd5, 3'd3, 1'b0, 8'h95, 8'h02, 16'h0003);
		add_ltsm(ST_SBINIT, 4'd2, 3'd0, 1'b0, 8'h9A, 8'h02, 16'h0000);
		// Out-of-reset within SBINIT clears the count
		add_ltsm(ST_SBINIT, 4'd3, 3'd0, 1'b0, 8'h91, 8'h00, 16'h0000);
		// New state restarts, one data message
		add_ltsm(ST_MBINIT, 4'd1, 3'd0, 1'b0, 8'hA5, 8'h00, 16'h0000);
		add_ltsm(ST_MBINIT, 4'd3, 3'd5, 1'b1, 8'hA5, 8'h01, 16'h0005);
		// Test table lookups
		add_test(PST_TX_POINT, 4'd1, 3'd0, 8'h85, 8'h01, 16'h0000);
		add_test(PST_TX_POINT, 4'd6, 3'd6, 8'h8A, 8'h03, 16'h0020);
		add_test(PST_TX_SWEEP, 4'd3, 3'd0, 8'h85, 8'h02, 16'h0000);
		add_test(PST_TX_SWEEP, 4'd8, 3'd2, 8'h8A, 8'h00, 16'h0002);
		add_test(PST_RX_POINT, 4'd7, 3'd0, 8'h85, 8'h09, 16'h0000);
		add_test(PST_RX_SWEEP, 4'd6, 3'd3, 8'h8A, 8'h0B, 16'h0030);
		add_test(PST_RX_SWEEP, 4'd9, 3'd0, 8'h81, 8'h0C, 16'h0000);
		// Counter picks up where it was before the tests
		add_ltsm(ST_MBINIT, 4'd4, 3'd0, 1'b0, 8'hAA, 8'h01, 16'h0000);
		add_ltsm(ST_MBINIT, 4'd5, 3'd0, 1'b0, 8'hA5, 8'h02, 16'h0000);
		// RDI info recoding
		add_rdi(RDI_NOP, RDI_CRD, 2'd0, 8'h00, 8'h00, 16'h0001);
		add_rdi(RDI_NOP, RDI_ACTIVE, 2'd3, 8'h00, 8'h01, 16'h0004);
		add_rdi(RDI_RESP, RDI_L1, 2'd1, 8'h02, 8'h03, 16'hFFFF);
		add_rdi(RDI_RESP, RDI_RETRAIN, 2'd2, 8'h02, 8'h07, 16'h0000);
		add_rdi(RDI_REQ, RDI_DISABLE, 2'd3, 8'h01, 8'h08, 16'h0000);
		// No restart, RDI left the last state alone
		add_ltsm(ST_MBINIT, 4'd7, 3'd0, 1'b0, 8'hA5, 8'h03, 16'h0000);
		// Frozen counter in TRAINERROR
		add_ltsm(ST_TRAINERROR, 4'd1, 3'd0, 1'b0, 8'h05, 8'h00, 16'h0000);
		// Back to back from here on
		b2b_mode = 1'b1;
		add_ltsm(ST_TRAINERROR, 4'd3, 3'd0, 1'b0, 8'h05, 8'h00, 16'h0000);
		add_ltsm(ST_TRAINERROR, 4'd2, 3'd0, 1'b0, 8'h0A, 8'h00, 16'h0000);
		// State changes with no gaps
		add_ltsm(ST_PHYRETRAIN, 4'd1, 3'd0, 1'b0, 8'hC5, 8'h00, 16'h0000);
		add_ltsm(ST_PHYRETRAIN, 4'd3, 3'd0, 1'b0, 8'hC5, 8'h01, 16'h0000);
		add_ltsm(ST_MBTRAIN, 4'd1, 3'd0, 1'b0, 8'hB5, 8'h00, 16'h0000);
		add_ltsm(ST_TRAINERROR_HS, 4'd1, 3'd0, 1'b0, 8'hE5, 8'h00, 16'h0000);
	endtask

	// ------------------------------------------------------------------
	// Driving and checking
	// ------------------------------------------------------------------
	task automatic apply_msg(input vec_t v);
		i_msg_valid = 1'b1;
		i_rdi_msg   = v.rdi;
		i_ltsm      = v.ltsm;
		i_rdi       = v.rdi_msg;
		exp_q.push_back(v.hdr);
	endtask

	task automatic check_header(input sb_header_t act, input sb_header_t expected);
		if (act !== expected) begin
			$display("Fail %0t ns: header %h, expected %h (%s %h/%h %h/%h %h/%h %h/%h)",
				$time, act, expected, "opcode code sub info",
				act.opcode, expected.opcode, act.msg_code, expected.msg_code,
				act.subcode, expected.subcode, act.info, expected.info);
			hdr_errs++;
		end
	endtask

	task automatic check_valid(input int act, input int expected);
		if (act != expected) begin
			$display("Fail %0t ns: %0d header pulses, expected %0d", $time, act, expected);
			cnt_errs++;
		end
	endtask

	// Outputs are settled by the falling edge
	always @(negedge i_clk) begin
		if (i_rst_n && o_header_valid) begin
			rx_count++;
			if (exp_q.size() == 0) begin
				$display("Header valid at %0t ns with no message pending", $time);
				cnt_errs++;
			end else begin
				exp_hdr = exp_q.pop_front();
				check_header(o_header, exp_hdr);
			end
		end
	end

	// Run limit
	always @(posedge i_clk) begin
		cycle_cnt++;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			$display("Timeout after %0d cycles: header stream stalled, %0d of %0d seen",
				cycle_cnt, rx_count, n_vec);
			$display("Simulation failed");
			$finish;
		end
	end

	initial begin
		i_rst_n     = 1'b0;
		i_msg_valid = 1'b0;
		i_rdi_msg   = 1'b0;
		i_ltsm      = '0;
		i_rdi       = '0;
		n_vec       = 0;
		b2b_mode    = 1'b0;
		rx_count    = 0;
		cycle_cnt   = 0;
		hdr_errs    = 0;
		cnt_errs    = 0;
		void'($urandom(87125));
		build_table();
		repeat (2) @(posedge i_clk);
		#5;
		i_rst_n = 1'b1;
		for (idx = 0; idx < n_vec; idx++) begin
			@(posedge i_clk);
			#5;
			apply_msg(tbl[idx]);
			// Random idle gap unless back to back
			if (!tbl[idx].b2b) begin
				gaps = $urandom_range(2, 0);
				repeat (gaps) begin
					@(posedge i_clk);
					#5;
					i_msg_valid = 1'b0;
				end
			end
		end
		@(posedge i_clk);
		#5;
		i_msg_valid = 1'b0;
		wait (rx_count >= n_vec);
		// Catch any extra pulse
		repeat (4) @(posedge i_clk);
		check_valid(rx_count, n_vec);
		$display("Errors: %0d header, %0d count", hdr_errs, cnt_errs);
		if (hdr_errs == 0 && cnt_errs == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule : tb_sb_header_encoder

`default_nettype wire
